/* Makefile */
# Verilator flow for the load/store subsystem

TB_TOP := tawas_ls_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module $(TB_TOP) -f tawas_ls_sys.f

sim:
	verilator --binary --timing --assert --top-module $(TB_TOP) -f tawas_ls_sys.f -o tawas_ls_sim
	./obj_dir/tawas_ls_sim | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

/* hw/tawas_dmem.sv */
// synchronous word-wide data memory behind the load/store unit, with per-byte write enables
`default_nettype none

module tawas_dmem
    import tawas_pkg::*;
(
    input  wire         clk,
    input  wire  [31:0] daddr,
    input  wire         dcs,
    input  wire         dwr,
    input  wire  [3:0]  dmask,
    input  wire  [31:0] dout,
    output logic [31:0] din
);

    localparam int idx_w = $clog2(dmem_words);

    logic [31:0]      mem [dmem_words];
    logic [idx_w-1:0] idx;

    assign idx = daddr[idx_w+1:2];                  // upper address bits alias

    always_ff @(posedge clk)
    begin
        if (dcs && dwr)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (dmask[b])
                    mem[idx][8*b +: 8] <= dout[8*b +: 8];
            end
        end
    end

    // read word is registered on every select, the unit only keeps it for loads
    always_ff @(posedge clk)
    begin
        if (dcs)
            din <= mem[idx];
    end

endmodule

`default_nettype wire

/* hw/tawas_ls.sv */
// load/store unit: turns one op word or direct descriptor into a data bus request and a writeback
`default_nettype none

module tawas_ls
    import tawas_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    output logic [31:0] daddr,
    output logic        dcs,
    output logic        rcn_cs,
    output logic [2:0]  writeback_reg,
    output logic        dwr,
    output logic [3:0]  dmask,
    output logic [31:0] dout,
    input  wire  [31:0] din,

    input  wire         ls_op_vld,
    input  wire  [14:0] ls_op,

    input  wire         ls_dir_vld,
    input  wire         ls_dir_store,
    input  wire  [2:0]  ls_dir_sel,
    input  wire  [31:0] ls_dir_addr,

    output logic [2:0]  ls_ptr_sel,
    input  wire  [31:0] ls_ptr,

    output logic [2:0]  ls_store_sel,
    input  wire  [31:0] ls_store,

    output logic        ls_ptr_upd_vld,
    output logic [2:0]  ls_ptr_upd_sel,
    output logic [31:0] ls_ptr_upd,

    output logic        ls_load_vld,
    output logic [2:0]  ls_load_sel,
    output logic [31:0] ls_load
);

    logic [1:0]  ls_size;
    logic [4:0]  off_fld;
    logic [2:0]  data_reg;
    logic        req;
    logic        wr_en;
    logic        rcn_space;
    logic [31:0] addr_offset;
    logic [31:0] addr_adj;
    logic [31:0] addr_next;
    logic [31:0] addr_out;
    logic [31:0] wr_data;
    logic [3:0]  data_mask;
    logic [7:0]  ld_d1;
    logic [7:0]  ld_d2;
    logic [7:0]  ld_d3;
    logic [31:0] rd_data;

    assign req = ls_op_vld || ls_dir_vld;
    assign ls_size = ls_dir_vld ? sz_word : ls_op[op_size_hi:op_size_lo];  // direct is always a word
    assign off_fld = ls_op[op_off_lsb+4:op_off_lsb];
    assign data_reg = ls_dir_vld ? ls_dir_sel : ls_op[op_data_lsb+2:op_data_lsb];

    assign ls_ptr_sel = ls_op[op_ptr_lsb+2:op_ptr_lsb];
    assign ls_store_sel = data_reg;

    always_comb
    begin
        if (ls_size[1])
        begin
            addr_offset = {25'd0, off_fld, 2'd0};
            addr_adj = {{25{off_fld[4]}}, off_fld, 2'd0};
        end
        else if (ls_size == sz_half)
        begin
            addr_offset = {26'd0, off_fld, 1'b0};
            addr_adj = {{26{off_fld[4]}}, off_fld, 1'b0};
        end
        else
        begin
            addr_offset = {27'd0, off_fld};
            addr_adj = {{27{off_fld[4]}}, off_fld};
        end
    end

    assign addr_next = ls_ptr + (ls_op[op_ptr_upd] ? addr_adj : addr_offset);

    // a positive adjustment is applied after the access, a negative one before it
    assign addr_out = ls_dir_vld ? ls_dir_addr :
                      (ls_op[op_ptr_upd] && !addr_adj[31]) ? ls_ptr : addr_next;

    assign rcn_space = addr_out[31];
    assign wr_en = (ls_dir_vld && ls_dir_store) || (ls_op_vld && ls_op[op_store]);

    always_comb
    begin
        if (ls_size[1])
        begin
            wr_data = ls_store;
            data_mask = 4'b1111;
        end
        else if (ls_size == sz_half)
        begin
            wr_data = {2{ls_store[15:0]}};
            data_mask = addr_out[1] ? 4'b1100 : 4'b0011;
        end
        else
        begin
            wr_data = {4{ls_store[7:0]}};
            data_mask = 4'b0001 << addr_out[1:0];
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dcs <= 1'b0;
            rcn_cs <= 1'b0;
            dwr <= 1'b0;
            dmask <= 4'b0000;
            ls_ptr_upd_vld <= 1'b0;
        end
        else
        begin
            dcs <= req && !rcn_space;
            rcn_cs <= req && rcn_space;         // ring-bus space takes its own select
            dwr <= req && wr_en;
            dmask <= req ? data_mask : 4'b0000;
            ls_ptr_upd_vld <= ls_op_vld && ls_op[op_ptr_upd];
        end
    end

    always_ff @(posedge clk)
    begin
        if (req)
        begin
            daddr <= {addr_out[31:2], 2'b00};
            dout <= wr_en ? wr_data : 32'd0;
            writeback_reg <= data_reg;
            ls_ptr_upd_sel <= ls_ptr_sel;
            ls_ptr_upd <= addr_next;
        end
    end

    // tag pipeline carries {load valid, size, byte offset, destination} to the writeback stage
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            ld_d1 <= 8'd0;
            ld_d2 <= 8'd0;
            ld_d3 <= 8'd0;
        end
        else
        begin
            ld_d1 <= req ? {!wr_en && !rcn_space, ls_size, addr_out[1:0], data_reg} : 8'd0;
            ld_d2 <= ld_d1;
            ld_d3 <= ld_d2;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ld_d2[7])
            rd_data <= din;
    end

    always_comb
    begin
        if (ld_d3[6])
            ls_load = rd_data;
        else if (ld_d3[6:5] == sz_half)
            ls_load = ld_d3[4] ? {16'd0, rd_data[31:16]} : {16'd0, rd_data[15:0]};
        else
        begin
            case (ld_d3[4:3])
                2'd0: ls_load = {24'd0, rd_data[7:0]};
                2'd1: ls_load = {24'd0, rd_data[15:8]};
                2'd2: ls_load = {24'd0, rd_data[23:16]};
                default: ls_load = {24'd0, rd_data[31:24]};
            endcase
        end
    end

    assign ls_load_vld = ld_d3[7];
    assign ls_load_sel = ld_d3[2:0];

endmodule

`default_nettype wire

/* hw/tawas_ls_ctrl.sv */
// APB slave and issue FSM: holds the operation registers, starts one operation and tracks completion
`default_nettype none

module tawas_ls_ctrl
    import tawas_pkg::*;
(
    input  wire         clk,
    input  wire         rst,

    input  wire  [11:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,

    input  wire         op_end,
    input  wire  [7:0]  rcn_count,

    input  wire  [31:0] reg_rdata,
    output logic        reg_we,
    output logic [2:0]  reg_sel,
    output logic [31:0] reg_wdata,

    output logic        issue,
    output logic        ls_op_vld,
    output logic        ls_dir_vld,
    output logic [14:0] ls_op,
    output logic        ls_dir_store,
    output logic [2:0]  ls_dir_sel,
    output logic [31:0] ls_dir_addr
);

    logic [1:0] state;
    logic       issue_dir;
    logic [7:0] done_cnt;
    logic       busy;
    logic       acc;
    logic       wr_acc;
    logic       hit_ctrl;
    logic       hit_op;
    logic       hit_dir;
    logic       hit_addr;
    logic       hit_status;
    logic       hit_reg;
    logic       start;

    assign acc = psel && penable;
    assign wr_acc = acc && pwrite;
    assign busy = state != st_idle;

    assign hit_ctrl = paddr == apb_ctrl;
    assign hit_op = paddr == apb_op;
    assign hit_dir = paddr == apb_dir;
    assign hit_addr = paddr == apb_dir_addr;
    assign hit_status = paddr == apb_status;
    assign hit_reg = paddr[11:5] == apb_reg_base[11:5];

    assign start = wr_acc && hit_ctrl && !busy && (pwdata[1:0] != 2'b00);

    assign pready = 1'b1;
    assign pslverr = acc && ((hit_ctrl && pwrite && busy) || (hit_reg && busy) ||
                             !(hit_ctrl || hit_op || hit_dir || hit_addr || hit_status || hit_reg));

    assign reg_sel = paddr[4:2];
    assign reg_wdata = pwdata;
    assign reg_we = wr_acc && hit_reg && !busy;

    always_comb
    begin
        prdata = 32'd0;
        if (hit_reg)
            prdata = reg_rdata;
        else if (hit_op)
            prdata = {17'd0, ls_op};
        else if (hit_dir)
            prdata = {28'd0, ls_dir_store, ls_dir_sel};
        else if (hit_addr)
            prdata = ls_dir_addr;
        else if (hit_status)
            prdata = {8'd0, rcn_count, done_cnt, 7'd0, busy};
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= st_idle;
            issue_dir <= 1'b0;
            done_cnt <= 8'd0;
        end
        else
        begin
            case (state)
                st_idle:
                    if (start)
                    begin
                        state <= st_issue;
                        issue_dir <= !pwdata[0];    // op word wins when both bits are set
                    end
                st_issue:
                    state <= st_wait;
                default:
                    if (op_end)
                    begin
                        state <= st_idle;
                        done_cnt <= done_cnt + 8'd1;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_acc && hit_op)
            ls_op <= pwdata[14:0];
        if (wr_acc && hit_dir)
        begin
            ls_dir_store <= pwdata[3];
            ls_dir_sel <= pwdata[2:0];
        end
        if (wr_acc && hit_addr)
            ls_dir_addr <= pwdata;
    end

    assign issue = state == st_issue;
    assign ls_op_vld = issue && !issue_dir;
    assign ls_dir_vld = issue && issue_dir;

endmodule

`default_nettype wire

/* hw/tawas_ls_timer.sv */
// tracks the load latency of the issued operation and counts ring-bus requests for status
`default_nettype none

module tawas_ls_timer
    import tawas_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        issue,
    input  wire        rcn_cs,
    output logic       op_end,
    output logic [7:0] rcn_count
);

    localparam int cnt_w = $clog2(ls_load_latency + 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            cnt <= '0;
        else if (issue)
            cnt <= cnt_w'(ls_load_latency);
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    assign op_end = cnt == cnt_w'(1);                // same cycle as the load writeback

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            rcn_count <= 8'd0;
        else if (rcn_cs)
            rcn_count <= rcn_count + 8'd1;
    end

endmodule

`default_nettype wire

/* hw/tawas_ls_top.sv */
// top level of the load/store subsystem with an APB host port, instantiated by the testbench
`default_nettype none

module tawas_ls_top
(
    input  wire         clk,
    input  wire         rst,
    input  wire  [11:0] paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    logic        op_end;
    logic [7:0]  rcn_count;
    logic        issue;
    logic [31:0] reg_rdata;
    logic        reg_we;
    logic [2:0]  reg_sel;
    logic [31:0] reg_wdata;
    logic        ls_op_vld;
    logic        ls_dir_vld;
    logic [14:0] ls_op;
    logic        ls_dir_store;
    logic [2:0]  ls_dir_sel;
    logic [31:0] ls_dir_addr;
    logic [2:0]  ls_ptr_sel;
    logic [31:0] ls_ptr;
    logic [2:0]  ls_store_sel;
    logic [31:0] ls_store;
    logic        ls_ptr_upd_vld;
    logic [2:0]  ls_ptr_upd_sel;
    logic [31:0] ls_ptr_upd;
    logic        ls_load_vld;
    logic [2:0]  ls_load_sel;
    logic [31:0] ls_load;
    logic [31:0] daddr;
    logic        dcs;
    logic        rcn_cs;
    logic        dwr;
    logic [3:0]  dmask;
    logic [31:0] dout;
    logic [31:0] din;

    tawas_ls_ctrl u_ctrl (
        .clk(clk), .rst(rst),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .op_end(op_end), .rcn_count(rcn_count),
        .reg_rdata(reg_rdata), .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata),
        .issue(issue), .ls_op_vld(ls_op_vld), .ls_dir_vld(ls_dir_vld), .ls_op(ls_op),
        .ls_dir_store(ls_dir_store), .ls_dir_sel(ls_dir_sel), .ls_dir_addr(ls_dir_addr)
    );

    tawas_ls_timer u_timer (
        .clk(clk), .rst(rst), .issue(issue), .rcn_cs(rcn_cs),
        .op_end(op_end), .rcn_count(rcn_count)
    );

    // writeback_reg has no consumer once the ring bus is left out
    tawas_ls u_ls (
        .clk(clk), .rst(rst),
        .daddr(daddr), .dcs(dcs), .rcn_cs(rcn_cs), .writeback_reg(), .dwr(dwr),
        .dmask(dmask), .dout(dout), .din(din),
        .ls_op_vld(ls_op_vld), .ls_op(ls_op),
        .ls_dir_vld(ls_dir_vld), .ls_dir_store(ls_dir_store), .ls_dir_sel(ls_dir_sel),
        .ls_dir_addr(ls_dir_addr),
        .ls_ptr_sel(ls_ptr_sel), .ls_ptr(ls_ptr), .ls_store_sel(ls_store_sel), .ls_store(ls_store),
        .ls_ptr_upd_vld(ls_ptr_upd_vld), .ls_ptr_upd_sel(ls_ptr_upd_sel), .ls_ptr_upd(ls_ptr_upd),
        .ls_load_vld(ls_load_vld), .ls_load_sel(ls_load_sel), .ls_load(ls_load)
    );

    tawas_regfile u_regfile (
        .clk(clk), .rst(rst),
        .ls_ptr_sel(ls_ptr_sel), .ls_store_sel(ls_store_sel),
        .ls_ptr(ls_ptr), .ls_store(ls_store),
        .ls_ptr_upd_vld(ls_ptr_upd_vld), .ls_ptr_upd_sel(ls_ptr_upd_sel), .ls_ptr_upd(ls_ptr_upd),
        .ls_load_vld(ls_load_vld), .ls_load_sel(ls_load_sel), .ls_load(ls_load),
        .reg_we(reg_we), .reg_sel(reg_sel), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
    );

    tawas_dmem u_dmem (
        .clk(clk), .daddr(daddr), .dcs(dcs), .dwr(dwr),
        .dmask(dmask), .dout(dout), .din(din)
    );

endmodule

`default_nettype wire

/* hw/tawas_pkg.sv */
// shared constants for the load/store subsystem, imported by every module and the testbench
`default_nettype none

package tawas_pkg;

    localparam logic [11:0] apb_ctrl = 12'h000;
    localparam logic [11:0] apb_op = 12'h004;
    localparam logic [11:0] apb_dir = 12'h008;
    localparam logic [11:0] apb_dir_addr = 12'h00c;
    localparam logic [11:0] apb_status = 12'h010;
    localparam logic [11:0] apb_reg_base = 12'h020;    // eight words, 4 bytes apart

    localparam int op_store = 14;
    localparam int op_ptr_upd = 13;
    localparam int op_size_hi = 12;
    localparam int op_size_lo = 11;
    localparam int op_off_lsb = 6;                      // 5-bit offset field
    localparam int op_ptr_lsb = 3;
    localparam int op_data_lsb = 0;

    localparam logic [1:0] sz_byte = 2'b00;
    localparam logic [1:0] sz_half = 2'b01;
    localparam logic [1:0] sz_word = 2'b10;             // any code with the high bit set is a word

    localparam int ls_load_latency = 3;
    localparam int dmem_words = 256;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_issue = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;

endpackage

`default_nettype wire

/* hw/tawas_regfile.sv */
// eight-entry register file with the load/store read and write ports and a host access port
`default_nettype none

module tawas_regfile
(
    input  wire         clk,
    input  wire         rst,

    input  wire  [2:0]  ls_ptr_sel,
    input  wire  [2:0]  ls_store_sel,
    output logic [31:0] ls_ptr,
    output logic [31:0] ls_store,

    input  wire         ls_ptr_upd_vld,
    input  wire  [2:0]  ls_ptr_upd_sel,
    input  wire  [31:0] ls_ptr_upd,

    input  wire         ls_load_vld,
    input  wire  [2:0]  ls_load_sel,
    input  wire  [31:0] ls_load,

    input  wire         reg_we,
    input  wire  [2:0]  reg_sel,
    input  wire  [31:0] reg_wdata,
    output logic [31:0] reg_rdata
);

    logic [31:0] regs [8];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            for (int i = 0; i < 8; i++)
                regs[i] <= 32'd0;
        end
        else
        begin
            for (int i = 0; i < 8; i++)
            begin
                if (ls_load_vld && (ls_load_sel == 3'(i)))
                    regs[i] <= ls_load;             // load data beats a pointer update
                else if (ls_ptr_upd_vld && (ls_ptr_upd_sel == 3'(i)))
                    regs[i] <= ls_ptr_upd;
                else if (reg_we && (reg_sel == 3'(i)))
                    regs[i] <= reg_wdata;
            end
        end
    end

    assign ls_ptr = regs[ls_ptr_sel];
    assign ls_store = regs[ls_store_sel];
    assign reg_rdata = regs[reg_sel];

endmodule

`default_nettype wire

/* tawas_ls_sys.f */
hw/tawas_pkg.sv
hw/tawas_ls.sv
hw/tawas_regfile.sv
hw/tawas_dmem.sv
hw/tawas_ls_ctrl.sv
hw/tawas_ls_timer.sv
hw/tawas_ls_top.sv
tb/tawas_ls_tb.sv

/* tb/tawas_ls_tb.sv */
// self-checking testbench for tawas_ls_top, run as the simulation top with a register and memory model
`default_nettype none

module tawas_ls_tb
    import tawas_pkg::*;
;

    logic        clk;
    logic        rst;
    logic [11:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic        rd_chk;                        // set while a transfer's readback is checked
    logic [31:0] rd_exp;
    logic        err_exp;
    int          check_errors = 0;
    int          timeouts = 0;

    logic [31:0] m_regs [8];
    logic [7:0]  m_mem [4*dmem_words];
    logic [7:0]  m_done;
    logic [7:0]  m_rcn;

    tawas_ls_top dut (
        .clk(clk), .rst(rst), .paddr(paddr), .psel(psel), .penable(penable),
        .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    assert property (@(posedge clk) disable iff (rst)
        (psel && penable && !pwrite && rd_chk) |-> (prdata == rd_exp))
    else
    begin
        check_errors++;
        $display("[ERROR] t=%0t prdata got %h expected %h", $time, $sampled(prdata),
                 $sampled(rd_exp));
    end

    assert property (@(posedge clk) disable iff (rst)
        (psel && penable) |-> (pslverr == err_exp))
    else
    begin
        check_errors++;
        $display("[ERROR] t=%0t pslverr got %b expected %b", $time, $sampled(pslverr),
                 $sampled(err_exp));
    end

    assert property (@(posedge clk) disable iff (rst) (psel && penable) |-> pready)
    else
    begin
        check_errors++;
        $display("[ERROR] t=%0t pready got %b expected 1", $time, $sampled(pready));
    end

    task automatic end_run();
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
        $display("check errors: %0d, timeouts: %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    endtask

    // back-to-back APB transfer; the task returns on the edge that ends the access phase
    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input logic [31:0] wdata,
                            input logic err, input logic chk, input logic [31:0] exp,
                            output logic [31:0] rdata);
        @(negedge clk);
        paddr = addr;
        pwrite = wr;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        err_exp = err;
        rd_chk = chk;
        rd_exp = exp;
        @(negedge clk);
        penable = 1'b1;
        #10 rdata = prdata;
        @(posedge clk);
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic err);
        logic [31:0] unused;
        apb_xfer(addr, 1'b1, data, err, 1'b0, 32'd0, unused);
    endtask

    task automatic check_read(input logic [11:0] addr, input logic [31:0] exp);
        logic [31:0] unused;
        apb_xfer(addr, 1'b0, 32'd0, 1'b0, 1'b1, exp, unused);
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        int          polls;
        st = 32'd1;
        polls = 0;
        while (st[0] && polls < 32)
        begin
            apb_xfer(apb_status, 1'b0, 32'd0, 1'b0, 1'b0, 32'd0, st);
            polls++;
        end
        if (st[0])
        begin
            timeouts++;
            $display("timeout: busy still set after %0d status polls", polls);
            end_run();
        end
    endtask

    task automatic set_reg(input int i, input logic [31:0] v);
        apb_write(apb_reg_base + 12'(4*i), v, 1'b0);
        m_regs[i] = v;
    endtask

    task automatic check_regs();
        for (int i = 0; i < 8; i++)
            check_read(apb_reg_base + 12'(4*i), m_regs[i]);
    endtask

    task automatic check_status();
        check_read(apb_status, {8'd0, m_rcn, m_done, 8'd0});
    endtask

    function automatic logic [31:0] fill_word(input int idx);
        logic [7:0] b;
        b = 8'(idx);
        return {b ^ 8'ha5, ~b, b + 8'h3c, b};
    endfunction

    function automatic logic [14:0] make_op(input logic st, input logic upd,
                                            input logic [1:0] sz, input logic [4:0] off,
                                            input logic [2:0] ptr, input logic [2:0] data);
        logic [14:0] op;
        op = '0;
        op[op_store] = st;
        op[op_ptr_upd] = upd;
        op[op_size_hi] = sz[1];
        op[op_size_lo] = sz[0];
        op[op_off_lsb +: 5] = off;
        op[op_ptr_lsb +: 3] = ptr;
        op[op_data_lsb +: 3] = data;
        return op;
    endfunction

    // memory side of one access: ring-bus addresses only bump the count
    function automatic void model_access(input logic st, input logic [1:0] sz,
                                         input logic [31:0] addr, input logic [2:0] dreg,
                                         input logic [31:0] sdata);
        int base;
        int lane;
        base = int'(addr[9:2]) * 4;
        lane = base + 2 * int'(addr[1]);
        if (addr[31])
            m_rcn++;
        else if (st && sz[1])
        begin
            for (int b = 0; b < 4; b++)
                m_mem[base + b] = sdata[8*b +: 8];
        end
        else if (st && sz == sz_half)
        begin
            m_mem[lane] = sdata[7:0];
            m_mem[lane + 1] = sdata[15:8];
        end
        else if (st)
            m_mem[int'(addr[9:0])] = sdata[7:0];
        else if (sz[1])
            m_regs[dreg] = {m_mem[base + 3], m_mem[base + 2], m_mem[base + 1], m_mem[base]};
        else if (sz == sz_half)
            m_regs[dreg] = {16'd0, m_mem[lane + 1], m_mem[lane]};
        else
            m_regs[dreg] = {24'd0, m_mem[int'(addr[9:0])]};
    endfunction

    function automatic void model_op(input logic [14:0] op);
        logic [1:0]  sz;
        logic [4:0]  off;
        logic [2:0]  p;
        logic [31:0] ptr;
        logic [31:0] sdata;
        logic [31:0] scaled;
        logic [31:0] adj;
        logic [31:0] addr;
        int          scale;
        sz = {op[op_size_hi], op[op_size_lo]};
        off = op[op_off_lsb +: 5];
        p = op[op_ptr_lsb +: 3];
        ptr = m_regs[p];
        sdata = m_regs[op[op_data_lsb +: 3]];
        scale = sz[1] ? 4 : (sz[0] ? 2 : 1);
        scaled = 32'(off) * 32'(scale);
        adj = 32'($signed(off)) * 32'(scale);
        addr = ptr + scaled;
        if (op[op_ptr_upd] && off[4])
        begin
            addr = ptr + adj;                   // pre-decrement
            m_regs[p] = addr;
        end
        else if (op[op_ptr_upd])
        begin
            addr = ptr;
            m_regs[p] = ptr + scaled;
        end
        model_access(op[op_store], sz, addr, op[op_data_lsb +: 3], sdata);
    endfunction

    task automatic run_op(input logic [14:0] op);
        apb_write(apb_op, {17'd0, op}, 1'b0);
        apb_write(apb_ctrl, 32'd1, 1'b0);
        model_op(op);
        m_done++;
        wait_idle();
    endtask

    task automatic run_dir(input logic st, input logic [2:0] sel, input logic [31:0] addr);
        apb_write(apb_dir, {28'd0, st, sel}, 1'b0);
        apb_write(apb_dir_addr, addr, 1'b0);
        apb_write(apb_ctrl, 32'd2, 1'b0);
        model_access(st, sz_word, addr, sel, m_regs[sel]);
        m_done++;
        wait_idle();
    endtask

    initial
    begin
        logic [1:0] sz;
        logic [4:0] off;
        logic [31:0] dummy;
        void'($urandom(53));
        rst = 1'b1;
        paddr = 12'd0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = 32'd0;
        rd_chk = 1'b0;
        rd_exp = 32'd0;
        err_exp = 1'b0;
        m_done = 8'd0;
        m_rcn = 8'd0;
        for (int i = 0; i < 8; i++)
            m_regs[i] = 32'd0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        check_status();
        for (int i = 0; i < dmem_words; i++)     // direct word stores fill the memory
        begin
            set_reg(7, fill_word(i));
            run_dir(1'b1, 3'd7, 32'(4*i));
        end
        check_status();

        for (int n = 0; n < 20; n++)
        begin
            set_reg(1, $urandom() & 32'h3fc);
            set_reg(2, $urandom());
            off = 5'($urandom());
            run_op(make_op(1'b1, 1'b0, sz_word, off, 3'd1, 3'd2));
            run_op(make_op(1'b0, 1'b0, sz_word, off, 3'd1, 3'd3));
            check_read(apb_reg_base + 12'd12, m_regs[3]);
        end

        for (int n = 0; n < 16; n++)
        begin
            set_reg(1, $urandom() & 32'h3ff);
            set_reg(2, $urandom());
            sz = ($urandom() % 2 != 0) ? sz_half : sz_byte;
            off = 5'($urandom());
            run_op(make_op(1'b1, 1'b0, sz, off, 3'd1, 3'd2));
            run_op(make_op(1'b0, 1'b0, sz, off, 3'd1, 3'd3));
            run_op(make_op(1'b0, 1'b0, sz_word, off, 3'd1, 3'd4));
            check_regs();
        end

        for (int n = 0; n < 16; n++)
        begin
            set_reg(5, 32'h180 + ($urandom() & 32'hff));
            set_reg(6, $urandom());
            sz = 2'($urandom() % 3);
            off = (n < 2) ? ((n == 0) ? 5'd3 : 5'b11110) : 5'($urandom());
            run_op(make_op(1'($urandom()), 1'b1, sz, off, 3'd5, 3'($urandom())));
            check_regs();
        end

        set_reg(5, 32'h1234_5678);
        run_dir(1'b1, 3'd5, 32'h0000_02a0);
        run_dir(1'b0, 3'd6, 32'h0000_02a0);
        run_dir(1'b0, 3'd4, 32'h0000_0104);
        check_regs();

        set_reg(1, 32'h8000_0040);              // ring-bus space
        set_reg(3, 32'hdead_beef);
        run_op(make_op(1'b0, 1'b0, sz_word, 5'd2, 3'd1, 3'd3));
        run_op(make_op(1'b1, 1'b0, sz_word, 5'd0, 3'd1, 3'd5));
        run_dir(1'b1, 3'd5, 32'h8000_0100);
        run_dir(1'b0, 3'd6, 32'h0000_0100);
        run_dir(1'b0, 3'd2, 32'h0000_0040);
        check_regs();
        check_status();

        set_reg(1, 32'h0000_0300);
        apb_write(apb_op, {17'd0, make_op(1'b0, 1'b0, sz_word, 5'd1, 3'd1, 3'd0)}, 1'b0);
        apb_write(apb_ctrl, 32'd1, 1'b0);
        model_op(make_op(1'b0, 1'b0, sz_word, 5'd1, 3'd1, 3'd0));
        m_done++;
        apb_write(apb_ctrl, 32'd1, 1'b1);       // refused while busy
        apb_write(apb_reg_base + 12'd8, 32'h5555_aaaa, 1'b1);
        wait_idle();
        apb_write(apb_dir, 32'h0000_0004, 1'b0);
        apb_write(apb_dir_addr, 32'h0000_0010, 1'b0);
        apb_write(apb_ctrl, 32'd2, 1'b0);
        model_access(1'b0, sz_word, 32'h0000_0010, 3'd4, m_regs[4]);
        m_done++;
        apb_xfer(apb_reg_base + 12'd4, 1'b0, 32'd0, 1'b1, 1'b0, 32'd0, dummy);
        apb_write(apb_ctrl, 32'd2, 1'b1);
        wait_idle();
        apb_write(12'h014, 32'd0, 1'b1);
        apb_xfer(12'h100, 1'b0, 32'd0, 1'b1, 1'b0, 32'd0, dummy);
        check_regs();
        check_status();

        end_run();
    end

endmodule

`default_nettype wire
